// File: source/dino_pkg.sv
package dino_pkg;

    typedef enum logic [1:0] {
        st_idle = 2'd0,
        st_run  = 2'd1,
        st_over = 2'd2,
        st_win  = 2'd3
    } game_state_t;

    localparam logic [8:0] SCREEN_W     = 9'd320;  // cactus spawn column
    localparam logic [8:0] DINO_X       = 9'd40;   // left edge of the dinosaur box
    localparam logic [8:0] DINO_W       = 9'd20;
    localparam logic [8:0] CACTUS_W     = 9'd20;
    localparam logic [8:0] CACTUS_SPEED = 9'd4;    // pixels per frame
    localparam logic [8:0] GAP_STEP     = 9'd32;   // extra spawn distance per gap code

    localparam logic [4:0] JUMP_V  = 5'd12;  // takeoff velocity
    localparam logic [4:0] GRAVITY = 5'd1;   // velocity lost per frame

    localparam logic [15:0] RNG_SEED = 16'hace1;
    localparam logic [15:0] RNG_TAPS = 16'hb400;  // galois feedback mask

    // four cactus sizes, chosen by the random type code
    function automatic logic [7:0] cactus_height(input logic [1:0] kind);
        logic [7:0] h;
        case (kind)
            2'd0:    h = 8'd16;
            2'd1:    h = 8'd24;
            2'd2:    h = 8'd32;
            default: h = 8'd40;
        endcase
        return h;
    endfunction

endpackage

// File: source/frame_rng.sv
`timescale 1ns/1ps

// free-running galois lfsr, the single source of randomness for the cactus
module frame_rng (
    input  logic        clk,
    input  logic        rst,
    output logic [15:0] rnd
);

    logic [15:0] rnd_shift;

    assign rnd_shift = {1'b0, rnd[15:1]};  // shift right, bit 0 falls out

    always_ff @(posedge clk, negedge rst) begin
        if (!rst) begin
            rnd <= dino_pkg::RNG_SEED;
        end else if (rnd[0]) begin
            rnd <= rnd_shift ^ dino_pkg::RNG_TAPS;  // feedback when a one leaves
        end else begin
            rnd <= rnd_shift;
        end
    end

endmodule

// File: source/dino_jump.sv
`timescale 1ns/1ps

module dino_jump (
    input  logic                  clk,
    input  logic                  rst,
    input  dino_pkg::game_state_t state,
    input  logic                  start,
    input  logic                  frame_tick,
    input  logic                  jump_req,
    output logic [7:0]            dino_y
);

    logic signed [5:0] vel;     // positive means rising
    logic signed [5:0] vel_eff;
    logic signed [9:0] h_next;
    logic              on_ground;

    assign on_ground = (dino_y == 8'd0);

    // a held button on the ground launches the dinosaur on this frame
    assign vel_eff = (on_ground && jump_req) ? $signed({1'b0, dino_pkg::JUMP_V}) : vel;
    assign h_next  = $signed({2'b00, dino_y}) + $signed({{4{vel_eff[5]}}, vel_eff});

    always_ff @(posedge clk, negedge rst) begin
        if (!rst) begin
            dino_y <= 8'd0;
            vel    <= 6'sd0;
        end else if (start) begin
            dino_y <= 8'd0;  // every game begins standing on the floor
            vel    <= 6'sd0;
        end else if (frame_tick && state == dino_pkg::st_run) begin
            if (h_next <= 10'sd0) begin
                dino_y <= 8'd0;  // landing clamps to the floor
                vel    <= 6'sd0;
            end else begin
                dino_y <= h_next[7:0];
                vel    <= vel_eff - $signed({1'b0, dino_pkg::GRAVITY});
            end
        end
    end

endmodule

// File: source/cactus_move.sv
`timescale 1ns/1ps

module cactus_move (
    input  logic                  clk,
    input  logic                  rst,
    input  dino_pkg::game_state_t state,
    input  logic                  start,
    input  logic                  frame_tick,
    input  logic [15:0]           rnd,
    output logic [8:0]            cactus_x,
    output logic [7:0]            cactus_h,
    output logic                  pass
);

    logic [1:0] gap_code;
    logic [1:0] type_code;
    logic [8:0] spawn_x;
    logic       off_left;

    assign gap_code  = rnd[1:0];
    assign type_code = rnd[3:2];

    // respawn column, somewhere between SCREEN_W and SCREEN_W + 3 * GAP_STEP
    assign spawn_x  = dino_pkg::SCREEN_W + ({7'd0, gap_code} * dino_pkg::GAP_STEP);
    assign off_left = (cactus_x < dino_pkg::CACTUS_SPEED);

    always_ff @(posedge clk, negedge rst) begin
        if (!rst) begin
            cactus_x <= dino_pkg::SCREEN_W;
            cactus_h <= dino_pkg::cactus_height(2'd0);
            pass     <= 1'b0;
        end else begin
            pass <= 1'b0;  // one-cycle pulse by default
            if (start) begin
                cactus_x <= dino_pkg::SCREEN_W;
                cactus_h <= dino_pkg::cactus_height(type_code);
            end else if (frame_tick && state == dino_pkg::st_run) begin
                if (off_left) begin
                    cactus_x <= spawn_x;  // the old cactus made it past, bring a new one
                    cactus_h <= dino_pkg::cactus_height(type_code);
                    pass     <= 1'b1;
                end else begin
                    cactus_x <= cactus_x - dino_pkg::CACTUS_SPEED;
                end
            end
        end
    end

endmodule

// File: source/collision_detector.sv
`timescale 1ns/1ps

module collision_detector (
    input  logic                  clk,
    input  logic                  rst,
    input  dino_pkg::game_state_t state,
    input  logic [7:0]            dino_y,
    input  logic [8:0]            cactus_x,
    input  logic [7:0]            cactus_h,
    output logic                  collides
);

    logic overlap;
    logic running;
    logic run_q;
    logic hit_q;

    assign running = (state == dino_pkg::st_run);

    assign overlap = (cactus_x < dino_pkg::DINO_X + dino_pkg::DINO_W)
                  && (cactus_x + dino_pkg::CACTUS_W > dino_pkg::DINO_X)
                  && (dino_y < cactus_h);

    // The first run cycle still shows the frozen boxes of the last game, so
    // the test only counts once the state has been st_run for a full cycle
    always_ff @(posedge clk, negedge rst) begin
        if (!rst) begin
            run_q <= 1'b0;
            hit_q <= 1'b0;
        end else begin
            run_q <= running;
            hit_q <= running && run_q && overlap;
        end
    end

    assign collides = hit_q && running;  // drops as soon as the game leaves st_run

endmodule

// File: source/game_fsm.sv
`timescale 1ns/1ps

module game_fsm #(
    parameter int FRAME_DIV = 833333
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  button,
    input  logic                  collides,
    input  logic                  win,
    output dino_pkg::game_state_t state,
    output logic                  start,
    output logic                  frame_tick,
    output logic                  jump_req
);

    localparam int CNT_W = $clog2(FRAME_DIV);

    logic                  sync0;
    logic                  sync1;
    logic                  btn_dly;
    logic                  press;
    logic [CNT_W-1:0]      frame_cnt;
    dino_pkg::game_state_t state_next;

    always_ff @(posedge clk, negedge rst) begin
        if (!rst) begin
            sync0   <= 1'b0;
            sync1   <= 1'b0;
            btn_dly <= 1'b0;
            press   <= 1'b0;
        end else begin
            sync0   <= button;  // two flops against metastability
            sync1   <= sync0;
            btn_dly <= sync1;
            press   <= sync1 & ~btn_dly;  // registered rising edge
        end
    end

    assign jump_req = sync1;

    always_ff @(posedge clk, negedge rst) begin
        if (!rst) begin
            frame_cnt  <= '0;
            frame_tick <= 1'b0;
        end else begin
            frame_tick <= (frame_cnt == CNT_W'(FRAME_DIV - 1));
            frame_cnt  <= (frame_cnt == CNT_W'(FRAME_DIV - 1)) ? '0 : frame_cnt + 1'b1;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            dino_pkg::st_idle: if (press) state_next = dino_pkg::st_run;
            dino_pkg::st_run: begin
                if (collides) state_next = dino_pkg::st_over;
                else if (win && !start) state_next = dino_pkg::st_win;  // old score clears on start
            end
            dino_pkg::st_over, dino_pkg::st_win: if (press) state_next = dino_pkg::st_idle;
            default: state_next = dino_pkg::st_idle;
        endcase
    end

    always_ff @(posedge clk, negedge rst) begin
        if (!rst) begin
            state <= dino_pkg::st_idle;
            start <= 1'b0;
        end else begin
            state <= state_next;
            start <= (state == dino_pkg::st_idle) && (state_next == dino_pkg::st_run);
        end
    end

endmodule

// File: source/score_counter.sv
`timescale 1ns/1ps

module score_counter #(
    parameter int WIN_SCORE = 99
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       start,
    input  logic       pass,
    output logic [3:0] score_ones,
    output logic [3:0] score_tens,
    output logic       win
);

    localparam logic [3:0] WIN_ONES = 4'(WIN_SCORE % 10);
    localparam logic [3:0] WIN_TENS = 4'(WIN_SCORE / 10);

    always_ff @(posedge clk, negedge rst) begin
        if (!rst) begin
            score_ones <= 4'd0;
            score_tens <= 4'd0;
        end else if (start) begin
            score_ones <= 4'd0;
            score_tens <= 4'd0;
        end else if (pass) begin
            if (score_ones == 4'd9) begin
                score_ones <= 4'd0;  // decimal carry into the tens digit
                score_tens <= (score_tens == 4'd9) ? 4'd0 : score_tens + 4'd1;
            end else begin
                score_ones <= score_ones + 4'd1;
            end
        end
    end

    assign win = (score_ones == WIN_ONES) && (score_tens == WIN_TENS);

endmodule

// File: source/dino_game_core.sv
`timescale 1ns/1ps

module dino_game_core #(
    parameter int FRAME_DIV = 833333,
    parameter int WIN_SCORE = 99
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  button,
    output dino_pkg::game_state_t state,
    output logic [7:0]            dino_y,
    output logic [8:0]            cactus_x,
    output logic [7:0]            cactus_h,
    output logic                  collides,
    output logic [3:0]            score_ones,
    output logic [3:0]            score_tens
);

    logic        start;
    logic        frame_tick;
    logic        jump_req;
    logic        win;
    logic        pass;
    logic [15:0] rnd;

    game_fsm #(.FRAME_DIV(FRAME_DIV)) u_fsm (
        .clk(clk), .rst(rst), .button(button), .collides(collides), .win(win),
        .state(state), .start(start), .frame_tick(frame_tick), .jump_req(jump_req)
    );

    frame_rng u_rng (.clk(clk), .rst(rst), .rnd(rnd));

    dino_jump u_jump (
        .clk(clk), .rst(rst), .state(state), .start(start), .frame_tick(frame_tick),
        .jump_req(jump_req), .dino_y(dino_y)
    );

    cactus_move u_cactus (
        .clk(clk), .rst(rst), .state(state), .start(start), .frame_tick(frame_tick),
        .rnd(rnd), .cactus_x(cactus_x), .cactus_h(cactus_h), .pass(pass)
    );

    collision_detector u_collide (
        .clk(clk), .rst(rst), .state(state), .dino_y(dino_y), .cactus_x(cactus_x),
        .cactus_h(cactus_h), .collides(collides)
    );

    score_counter #(.WIN_SCORE(WIN_SCORE)) u_score (
        .clk(clk), .rst(rst), .start(start), .pass(pass),
        .score_ones(score_ones), .score_tens(score_tens), .win(win)
    );

endmodule

// File: tb/dino_game_checker.sv
`timescale 1ns/1ps

module dino_game_checker (
    input logic                  clk,
    input logic                  rst,
    input dino_pkg::game_state_t state,
    input logic [7:0]            dino_y,
    input logic [8:0]            cactus_x,
    input logic                  collides,
    input logic [3:0]            score_ones,
    input logic [3:0]            score_tens
);

    int   fail_count = 0;  // number of failed assertions so far
    logic played;          // high once the first game has started

    always_ff @(posedge clk, negedge rst) begin
        if (!rst) begin
            played <= 1'b0;
        end else if (state == dino_pkg::st_run) begin
            played <= 1'b1;
        end
    end

    a_hit_only_in_run: assert property (@(posedge clk) disable iff (!rst)
        state != dino_pkg::st_run |-> !collides)
    else begin
        $error("collides is set outside st_run");
        fail_count++;
    end

    a_score_frozen: assert property (@(posedge clk) disable iff (!rst)
        state != dino_pkg::st_run |-> $stable({score_tens, score_ones}))
    else begin
        $error("score changed outside st_run");
        fail_count++;
    end

    a_cactus_range: assert property (@(posedge clk) disable iff (!rst)
        cactus_x <= dino_pkg::SCREEN_W + 3 * dino_pkg::GAP_STEP)
    else begin
        $error("cactus_x is beyond the farthest spawn column");
        fail_count++;
    end

    a_idle_on_floor: assert property (@(posedge clk) disable iff (!rst)
        (state == dino_pkg::st_idle && !played) |-> dino_y == 8'd0)
    else begin
        $error("dino_y left the floor before the first game");
        fail_count++;
    end

endmodule

bind dino_game_core dino_game_checker u_checker (
    .clk(clk), .rst(rst), .state(state), .dino_y(dino_y), .cactus_x(cactus_x),
    .collides(collides), .score_ones(score_ones), .score_tens(score_tens)
);

// File: tb/dino_game_tb.sv
`timescale 1ns/1ps

module dino_game_tb;

    localparam int FRAME_DIV     = 4;
    localparam int WIN_SCORE     = 5;
    localparam int CACTUS_FRAMES = 104;                // longest trip of one cactus, 416 / 4
    localparam int PLAN_FRAMES   = 9 * CACTUS_FRAMES;  // 5, 1 and 3 cacti over three games
    localparam int MARGIN_NS     = 10000;

    typedef struct packed {
        logic              sync0, sync1, btn_dly, press, frame_tick, start, pass;
        logic [15:0]       frame_cnt;
        logic [1:0]        state;
        logic [15:0]       rnd;
        logic [7:0]        dino_y;
        logic signed [7:0] vel;
        logic [8:0]        cactus_x;
        logic [7:0]        cactus_h;
        logic              run_q, hit_q;
        logic [7:0]        score;  // plain count, split into digits on compare
    } core_model_t;

    logic                  clk = 1'b0;  // low from the start so time zero holds no clock edge
    logic                  rst;
    logic                  button;
    dino_pkg::game_state_t state;
    logic [7:0]            dino_y;
    logic [8:0]            cactus_x;
    logic [7:0]            cactus_h;
    logic                  collides;
    logic [3:0]            score_ones;
    logic [3:0]            score_tens;
    logic [31:0]           lfsr_state;
    int                    error_count;
    core_model_t           model;

    dino_game_core #(
        .FRAME_DIV(FRAME_DIV),
        .WIN_SCORE(WIN_SCORE)
    ) u_dut (
        .clk(clk), .rst(rst), .button(button), .state(state), .dino_y(dino_y),
        .cactus_x(cactus_x), .cactus_h(cactus_h), .collides(collides),
        .score_ones(score_ones), .score_tens(score_tens)
    );

    initial begin
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    function automatic int draw_bits(input int nbits);
        int value;
        int i;
        value = 0;
        for (i = 0; i < nbits; i++) begin
            lfsr_state = lfsr_next(lfsr_state);  // one step per bit taken
            value      = (value << 1) | lfsr_state[0];
        end
        return value;
    endfunction

    function automatic logic [7:0] height_of(input logic [1:0] code);
        return 8'd16 + 8'd8 * code;  // 16, 24, 32 or 40 pixels
    endfunction

    function automatic core_model_t reset_model();
        core_model_t r;
        r          = '0;
        r.state    = dino_pkg::st_idle;
        r.rnd      = dino_pkg::RNG_SEED;
        r.cactus_x = dino_pkg::SCREEN_W;
        r.cactus_h = height_of(2'd0);
        return r;
    endfunction

    // one clock of the whole core, built from the game rules
    function automatic core_model_t step_model(input core_model_t m, input logic btn);
        core_model_t n;
        logic        running;
        logic        overlap;
        logic [1:0]  next_state;
        int          v_eff;
        int          h;
        n       = m;
        running = (m.state == dino_pkg::st_run);
        {n.sync0, n.sync1, n.btn_dly} = {btn, m.sync0, m.sync1};
        n.press      = m.sync1 && !m.btn_dly;
        n.frame_tick = (m.frame_cnt == FRAME_DIV - 1);
        n.frame_cnt  = n.frame_tick ? 16'd0 : m.frame_cnt + 16'd1;
        n.rnd        = {1'b0, m.rnd[15:1]} ^ (m.rnd[0] ? dino_pkg::RNG_TAPS : 16'h0000);
        next_state   = m.state;
        case (m.state)
            dino_pkg::st_idle: if (m.press) next_state = dino_pkg::st_run;
            dino_pkg::st_run: begin
                if (m.hit_q) next_state = dino_pkg::st_over;
                else if (m.score == WIN_SCORE && !m.start) next_state = dino_pkg::st_win;
            end
            default: if (m.press) next_state = dino_pkg::st_idle;
        endcase
        n.state = next_state;
        n.start = (m.state == dino_pkg::st_idle) && (next_state == dino_pkg::st_run);
        n.pass  = 1'b0;
        if (m.start) begin
            n.dino_y   = 8'd0;
            n.vel      = 8'sd0;
            n.cactus_x = dino_pkg::SCREEN_W;
            n.cactus_h = height_of(m.rnd[3:2]);
        end else if (m.frame_tick && running) begin
            if (m.dino_y == 8'd0 && m.sync1) v_eff = dino_pkg::JUMP_V;
            else v_eff = $signed(m.vel);
            h = int'(m.dino_y) + v_eff;
            n.dino_y = (h <= 0) ? 8'd0 : 8'(h);
            n.vel    = (h <= 0) ? 8'sd0 : 8'(v_eff - int'(dino_pkg::GRAVITY));
            if (m.cactus_x < dino_pkg::CACTUS_SPEED) begin
                n.cactus_x = dino_pkg::SCREEN_W + m.rnd[1:0] * dino_pkg::GAP_STEP;
                n.cactus_h = height_of(m.rnd[3:2]);
                n.pass     = 1'b1;
            end else begin
                n.cactus_x = m.cactus_x - dino_pkg::CACTUS_SPEED;
            end
        end
        overlap = (int'(m.cactus_x) < int'(dino_pkg::DINO_X) + int'(dino_pkg::DINO_W))
               && (int'(m.cactus_x) + int'(dino_pkg::CACTUS_W) > int'(dino_pkg::DINO_X))
               && (m.dino_y < m.cactus_h);
        n.run_q = running;
        n.hit_q = running && m.run_q && overlap;
        if (m.start) n.score = 8'd0;
        else if (m.pass) n.score = 8'((m.score + 1) % 100);
        return n;
    endfunction

    task automatic check(input string name, input logic [15:0] got, input logic [15:0] exp);
        if (got !== exp) begin
            error_count++;
            $display("MISMATCH %s: got %h expected %h", name, got, exp);
            $display("test failed");
            $fatal(1, "stopped at the first error");
        end
    endtask

    always @(posedge clk) begin
        if (!rst) model <= reset_model();
        else model <= step_model(model, button);  // sees the button before this edge's update
    end

    always @(negedge clk) begin
        check("state", 16'(state), 16'(model.state));
        check("dino_y", 16'(dino_y), 16'(model.dino_y));
        check("cactus_x", 16'(cactus_x), 16'(model.cactus_x));
        check("cactus_h", 16'(cactus_h), 16'(model.cactus_h));
        check("collides", 16'(collides), 16'(model.hit_q && model.state == dino_pkg::st_run));
        check("score_ones", 16'(score_ones), 16'(model.score % 10));
        check("score_tens", 16'(score_tens), 16'(model.score / 10));
        check("assertion failures", 16'(u_dut.u_checker.fail_count), 16'd0);
    end

    task automatic press_button();
        button <= 1'b1;
        repeat (4 + draw_bits(4)) @(posedge clk);  // long enough to span a frame tick
        button <= 1'b0;
        repeat (2 + draw_bits(4)) @(posedge clk);
    endtask

    task automatic wait_state(input dino_pkg::game_state_t s);
        while (state != s) @(posedge clk);
    endtask

    // jump over the first cacti, then let the game run to its end
    task automatic play(input int jumps);
        int dodged;
        int limit;
        dodged = 0;
        limit  = 80 + 4 * draw_bits(2);
        wait_state(dino_pkg::st_run);
        @(posedge clk);  // the start cycle still shows the old positions
        while (state == dino_pkg::st_run) begin
            if (dodged < jumps && cactus_x <= limit) begin
                press_button();
                dodged++;
                limit = 80 + 4 * draw_bits(2);
                while (state == dino_pkg::st_run && cactus_x <= 200) @(posedge clk);
            end else begin
                @(posedge clk);
            end
        end
    endtask

    initial begin
        #(PLAN_FRAMES * FRAME_DIV * 10 + MARGIN_NS);
        $display("watchdog expired, the game never finished");
        $display("test failed");
        $fatal(1, "timeout");
    end

    initial begin
        rst         = 1'b0;
        button      = 1'b0;
        lfsr_state  = 32'hdf1f;
        error_count = 0;
        repeat (8) @(posedge clk);
        rst <= 1'b1;
        repeat (12 + draw_bits(4)) @(posedge clk);  // idle with the button untouched
        press_button();
        play(99);
        check("state after game 1", 16'(state), 16'(dino_pkg::st_win));
        press_button();
        wait_state(dino_pkg::st_idle);
        press_button();
        play(0);
        check("state after game 2", 16'(state), 16'(dino_pkg::st_over));
        press_button();
        wait_state(dino_pkg::st_idle);
        press_button();
        play(2);
        check("state after game 3", 16'(state), 16'(dino_pkg::st_over));
        press_button();
        wait_state(dino_pkg::st_idle);
        repeat (20) @(posedge clk);
        if (error_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// File: sources.f
source/dino_pkg.sv
source/frame_rng.sv
source/dino_jump.sv
source/cactus_move.sv
source/collision_detector.sv
source/game_fsm.sv
source/score_counter.sv
source/dino_game_core.sv
tb/dino_game_checker.sv
tb/dino_game_tb.sv

// File: Bender.yml
package:
  name: dino_game

sources:
  - source/dino_pkg.sv
  - source/frame_rng.sv
  - source/dino_jump.sv
  - source/cactus_move.sv
  - source/collision_detector.sv
  - source/game_fsm.sv
  - source/score_counter.sv
  - source/dino_game_core.sv
  - target: simulation
    files:
      - tb/dino_game_checker.sv
      - tb/dino_game_tb.sv
